// ==== dbg_top.f ====
rtl/dbg_pkg.sv
rtl/jtag_dtm.sv
rtl/dmi_decoder.sv
rtl/mailbox_bank.sv
rtl/dmi_resp_mux.sv
rtl/dbg_top.sv
verif/dbg_top_sva.sv
verif/dbg_top_tb.sv

// ==== Makefile ====
# verilator build and run for the debug transport testbench

TOP = dbg_top_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f dbg_top.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/dbg_top_golden.txt ====
# test id, ir code, dr scan length, value shifted in, expected captured value (all hex but id and length)
# dbus values are {addr[40:34], data[33:2], op or status[1:0]}
1 01 32 0 1d7a0c4b
1 1f 8 a5 4a
2 10 32 0 71
3 11 41 2048d159e2 0
3 11 41 226af37bc2 2000000000
3 11 41 2000000001 2000000000
3 11 41 2400000001 226af37bc0
3 11 41 1800000001 2400000008
4 11 41 8000000001 1800000000
4 11 41 237ab6fbbe 8000000002
4 10 32 0 871
4 10 32 10000 871
4 10 32 0 71
4 11 41 2000000001 2000000000
4 11 41 2400000001 226af37bc0
5 10 32 20000 71
5 11 41 2000000001 2400000008
5 11 41 2400000001 2000000000
5 11 41 0 2400000000

// ==== verif/dbg_top_tb.sv ====
// testbench bit-banging jtag scans from golden vectors into the debug transport top
module dbg_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic tck = 1'b0;
    logic trst, tms, tdi;
    logic tdo;

    int errors = 0;
    int cycles = 0;
    int limit = 100;

    // one golden vector entry per scan
    int          vec_id[$];
    logic [4:0]  vec_ir[$];
    int          vec_len[$];
    logic [63:0] vec_in[$];
    logic [63:0] vec_exp[$];

    dbg_top dbg_top_inst (
        .i_tck  (tck),
        .i_trst (trst),
        .i_tms  (tms),
        .i_tdi  (tdi),
        .o_tdo  (tdo)
    );

    always #50 tck = ~tck;

    always @(posedge tck) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    // one tck cycle with inputs changing 10 ns after the rising edge
    task automatic step(input logic t_ms, input logic t_di);
        tms = t_ms;
        tdi = t_di;
        @(posedge tck);
        #10;
    endtask

    task automatic tap_reset();
        repeat (5) step(1'b1, 1'b0);
        step(1'b0, 1'b0);               // run-test/idle
    endtask

    task automatic run_idle();
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);
    endtask

    task automatic ir_scan(input logic [4:0] code);
        logic [4:0] cap;

        cap = '0;
        step(1'b1, 1'b0);               // select dr
        step(1'b1, 1'b0);               // select ir
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);               // now in shift ir
        for (int i = 0; i < 5; i++) begin
            cap[i] = tdo;
            step(i == 4, code[i]);
        end
        step(1'b1, 1'b0);               // update ir
        step(1'b0, 1'b0);
        check_value("ir capture", 64'(cap), 64'h01);
    endtask

    task automatic dr_scan(input int len, input logic [63:0] din, output logic [63:0] dout);
        dout = '0;
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);               // capture dr
        step(1'b0, 1'b0);
        for (int i = 0; i < len; i++) begin
            dout[i] = tdo;              // lsb leaves first
            step(i == len - 1, din[i]);
        end
        step(1'b1, 1'b0);               // update dr
        step(1'b0, 1'b0);
    endtask

    initial begin
        int fd;
        int id, len, test_start, scans, tests_ok, tests_bad;
        logic [4:0] ir, cur_ir;
        logic [63:0] din, dexp, got;
        string line;

        trst = 1'b1;
        tms = 1'b1;
        tdi = 1'b0;
        tests_ok = 0;
        tests_bad = 0;
        scans = 0;

        fd = $fopen("verif/dbg_top_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden vector file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %h %d %h %h", id, ir, len, din, dexp) == 5) begin
                    vec_id.push_back(id);
                    vec_ir.push_back(ir);
                    vec_len.push_back(len);
                    vec_in.push_back(din);
                    vec_exp.push_back(dexp);
                    limit += len + 24;  // ir scan, dr walk and idle per line
                end
            end
            $fclose(fd);
        end
        if (vec_id.size() == 0) begin
            $display("no golden vectors were loaded");
            errors++;
        end

        repeat (5) @(posedge tck);
        #10;
        trst = 1'b0;
        tap_reset();
        cur_ir = 5'h01;                 // idcode after tap reset
        test_start = errors;

        for (int i = 0; i < vec_id.size(); i++) begin
            if (vec_ir[i] != cur_ir) begin
                ir_scan(vec_ir[i]);
                cur_ir = vec_ir[i];
            end
            dr_scan(vec_len[i], vec_in[i], got);
            run_idle();
            check_value($sformatf("test %0d line %0d", vec_id[i], i), got, vec_exp[i]);
            scans++;
            if (i == vec_id.size() - 1 || vec_id[i + 1] != vec_id[i]) begin
                if (errors == test_start) begin
                    tests_ok++;
                    $display("test %0d finished: %0d scans, ok", vec_id[i], scans);
                end else begin
                    tests_bad++;
                    $display("test %0d finished: %0d scans, %0d errors", vec_id[i], scans,
                             errors - test_start);
                end
                test_start = errors;
                scans = 0;
            end
        end

        if (dbg_top_inst.dbg_top_sva_inst.fail_count != 0) begin
            $display("bound assertions failed %0d times",
                     dbg_top_inst.dbg_top_sva_inst.fail_count);
            errors += dbg_top_inst.dbg_top_sva_inst.fail_count;
        end

        $display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verif/dbg_top_sva.sv ====
// dmi strobe and busy timing checks bound into the debug top level
module dbg_top_sva import dbg_pkg::*; (
    input logic                 i_tck,
    input logic                 i_trst,
    input logic                 i_req_valid,
    input logic                 i_busy,
    input logic [NUM_BANKS-1:0] i_bank_wr_en
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    a_valid_pulse: assert property (@(posedge i_tck) disable iff (i_trst)
        i_req_valid |=> !i_req_valid)
        else begin
            $error("dmi request valid stayed high for more than one cycle");
            fail_count++;
        end

    // decoder reports busy right after taking a request
    a_busy_after_valid: assert property (@(posedge i_tck) disable iff (i_trst)
        i_req_valid |=> i_busy)
        else begin
            $error("busy did not follow a dmi request");
            fail_count++;
        end

    a_wr_onehot: assert property (@(posedge i_tck) disable iff (i_trst)
        $onehot0(i_bank_wr_en))
        else begin
            $error("more than one bank write strobe active");
            fail_count++;
        end

endmodule

bind dbg_top dbg_top_sva dbg_top_sva_inst (
    .i_tck        (i_tck),
    .i_trst       (i_trst),
    .i_req_valid  (req_valid),
    .i_busy       (dmi_busy),
    .i_bank_wr_en (bank_wr_en)
);

// ==== rtl/dbg_top.sv ====
// debug transport top joining the dtm, dmi decoder, mailbox banks and response mux
module dbg_top import dbg_pkg::*; (
    input  logic i_tck,
    input  logic i_trst,
    input  logic i_tms,
    input  logic i_tdi,
    output logic o_tdo
);

    logic req_valid, req_write;
    dmi_addr_t req_addr;
    dmi_data_t req_data;
    dmi_data_t resp_data;
    logic dmi_busy, dmi_error;
    logic hardreset;

    logic [NUM_BANKS-1:0] bank_wr_en;
    dmi_data_t wr_data;
    logic bank_clear;
    bank_idx_t sel_idx;
    logic sel_word, rd_en;
    dmi_data_t bank_data [NUM_BANKS];
    wr_count_t bank_count [NUM_BANKS];

    jtag_dtm jtag_dtm_inst (
        .i_tck           (i_tck),
        .i_trst          (i_trst),
        .i_tms           (i_tms),
        .i_tdi           (i_tdi),
        .o_tdo           (o_tdo),
        .o_dmi_req_valid (req_valid),
        .o_dmi_req_write (req_write),
        .o_dmi_req_addr  (req_addr),
        .o_dmi_req_data  (req_data),
        .i_dmi_resp_data (resp_data),
        .i_dmi_busy      (dmi_busy),
        .i_dmi_error     (dmi_error),
        .o_dmi_hardreset (hardreset)
    );

    dmi_decoder dmi_decoder_inst (
        .i_tck        (i_tck),
        .i_trst       (i_trst),
        .i_req_valid  (req_valid),
        .i_req_write  (req_write),
        .i_req_addr   (req_addr),
        .i_req_data   (req_data),
        .i_hardreset  (hardreset),
        .o_bank_wr_en (bank_wr_en),
        .o_wr_data    (wr_data),
        .o_clear      (bank_clear),
        .o_sel_idx    (sel_idx),
        .o_sel_word   (sel_word),
        .o_rd_en      (rd_en),
        .o_busy       (dmi_busy),
        .o_error      (dmi_error)
    );

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        mailbox_bank mailbox_bank_inst (
            .i_tck     (i_tck),
            .i_trst    (i_trst),
            .i_wr_en   (bank_wr_en[k]),
            .i_clear   (bank_clear),
            .i_wr_data (wr_data),
            .o_data    (bank_data[k]),
            .o_count   (bank_count[k])
        );
    end

    dmi_resp_mux dmi_resp_mux_inst (
        .i_tck        (i_tck),
        .i_trst       (i_trst),
        .i_rd_en      (rd_en),
        .i_sel_idx    (sel_idx),
        .i_sel_word   (sel_word),
        .i_bank_data  (bank_data),
        .i_bank_count (bank_count),
        .o_resp_data  (resp_data)
    );

endmodule

// ==== rtl/dmi_resp_mux.sv ====
// response multiplexer registering the addressed mailbox word as dmi read data
module dmi_resp_mux import dbg_pkg::*; (
    input  logic      i_tck,
    input  logic      i_trst,
    input  logic      i_rd_en,
    input  bank_idx_t i_sel_idx,
    input  logic      i_sel_word,
    input  dmi_data_t i_bank_data [NUM_BANKS],
    input  wr_count_t i_bank_count [NUM_BANKS],
    output dmi_data_t o_resp_data
);

    dmi_data_t sel_word;
    dmi_data_t resp_q;

    // counter is zero extended to a full word
    assign sel_word = i_sel_word ? dmi_data_t'(i_bank_count[i_sel_idx])
                                 : i_bank_data[i_sel_idx];

    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            resp_q <= '0;
        end else if (i_rd_en) begin
            resp_q <= sel_word;               // held until the next read
        end
    end

    assign o_resp_data = resp_q;

endmodule

// ==== rtl/mailbox_bank.sv ====
// mailbox bank with one data word and a wrapping write counter
module mailbox_bank import dbg_pkg::*; (
    input  logic      i_tck,
    input  logic      i_trst,
    input  logic      i_wr_en,
    input  logic      i_clear,
    input  dmi_data_t i_wr_data,
    output dmi_data_t o_data,
    output wr_count_t o_count
);

    dmi_data_t data_q;
    wr_count_t count_q;

    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            data_q <= '0;
            count_q <= '0;
        end else if (i_clear) begin
            data_q <= '0;                     // hardreset wipes the bank
            count_q <= '0;
        end else if (i_wr_en) begin
            data_q <= i_wr_data;
            count_q <= count_q + wr_count_t'(1);   // wraps at 255
        end
    end

    assign o_data = data_q;
    assign o_count = count_q;

endmodule

// ==== rtl/dmi_decoder.sv ====
// dmi request decoder driving mailbox write strobes, read select, busy and error
module dmi_decoder import dbg_pkg::*; (
    input  logic                 i_tck,
    input  logic                 i_trst,
    input  logic                 i_req_valid,
    input  logic                 i_req_write,
    input  dmi_addr_t            i_req_addr,
    input  dmi_data_t            i_req_data,
    input  logic                 i_hardreset,
    output logic [NUM_BANKS-1:0] o_bank_wr_en,
    output dmi_data_t            o_wr_data,
    output logic                 o_clear,
    output bank_idx_t            o_sel_idx,
    output logic                 o_sel_word,
    output logic                 o_rd_en,
    output logic                 o_busy,
    output logic                 o_error
);

    dmi_addr_t offset;
    logic hit;
    logic req_q, write_q, hit_q, word_q, error_q, clear_q;
    bank_idx_t idx_q;
    dmi_data_t data_q;

    // window check on the incoming address
    assign offset = i_req_addr - BANK_BASE;
    assign hit = (i_req_addr >= BANK_BASE) && (offset < dmi_addr_t'(2 * NUM_BANKS));

    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            req_q <= 1'b0;
            error_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            req_q <= i_req_valid;
            clear_q <= i_hardreset;
            if (i_req_valid) begin
                error_q <= !hit;              // held until the next request
            end
        end
    end

    // request payload
    always_ff @(posedge i_tck) begin
        if (i_req_valid) begin
            write_q <= i_req_write;
            hit_q <= hit;
            idx_q <= offset[$bits(bank_idx_t):1];
            word_q <= offset[0];              // odd address selects the counter
            data_q <= i_req_data;
        end
    end

    // counters are read only, so only data words take writes
    assign o_bank_wr_en = (req_q && write_q && hit_q && !word_q) ?
                          (NUM_BANKS'(1) << idx_q) : '0;
    assign o_wr_data = data_q;
    assign o_rd_en = req_q && hit_q && !write_q;
    assign o_sel_idx = idx_q;
    assign o_sel_word = word_q;
    assign o_busy = req_q;
    assign o_error = error_q;
    assign o_clear = clear_q;

endmodule

// ==== rtl/jtag_dtm.sv ====
// jtag tap controller and debug transport turning dbus scans into dmi requests
module jtag_dtm import dbg_pkg::*; (
    input  logic      i_tck,
    input  logic      i_trst,
    input  logic      i_tms,
    input  logic      i_tdi,
    output logic      o_tdo,
    output logic      o_dmi_req_valid,
    output logic      o_dmi_req_write,
    output dmi_addr_t o_dmi_req_addr,
    output dmi_data_t o_dmi_req_data,
    input  dmi_data_t i_dmi_resp_data,
    input  logic      i_dmi_busy,
    input  logic      i_dmi_error,
    output logic      o_dmi_hardreset
);

    tap_state_t state, state_nxt;
    ir_t ir;
    logic [DRLEN-1:0] dr, dr_nxt;
    logic [5:0] dr_len, len_nxt;       // active chain length
    dmi_stat_t sticky, sticky_nxt;
    logic pending, pending_nxt;        // last request not yet reported
    logic busy_q;
    dmi_addr_t last_addr, addr_nxt;
    logic [1:0] dbus_op;
    logic upd_dbus, upd_ctrl;
    logic req_fire;

    // standard tap transitions
    always_comb begin
        case (state)
            TAP_RESET:      state_nxt = i_tms ? TAP_RESET : TAP_IDLE;
            TAP_IDLE:       state_nxt = i_tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  state_nxt = i_tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_nxt = i_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_nxt = i_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_nxt = i_tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_nxt = i_tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_nxt = i_tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  state_nxt = i_tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  state_nxt = i_tms ? TAP_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: state_nxt = i_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_nxt = i_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_nxt = i_tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_nxt = i_tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_nxt = i_tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_nxt = i_tms ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_nxt = TAP_RESET;
        endcase
    end

    assign dbus_op = dr[1:0];
    assign upd_dbus = (state == TAP_UPDATE_DR) && (ir == IR_DBUS);
    assign upd_ctrl = (state == TAP_UPDATE_DR) && (ir == IR_DTMCONTROL);

    // requests only go out with a clean status and an idle decoder
    assign req_fire = upd_dbus && (dbus_op != 2'd0) && (sticky == DMISTAT_SUCCESS) && !busy_q;

    always_comb begin
        dmi_stat_t stat;

        dr_nxt = dr;
        len_nxt = dr_len;
        sticky_nxt = sticky;
        pending_nxt = pending;
        addr_nxt = last_addr;
        stat = sticky;
        case (state)
            TAP_CAPTURE_DR: begin
                dr_nxt = '0;
                case (ir)
                    IR_IDCODE: begin
                        dr_nxt[31:0] = IDCODE;
                        len_nxt = 6'd32;
                    end
                    IR_DTMCONTROL: begin
                        dr_nxt[3:0] = 4'h1;           // version
                        dr_nxt[9:4] = 6'(ABITS);
                        dr_nxt[11:10] = sticky;
                        len_nxt = 6'd32;
                    end
                    IR_DBUS: begin
                        if (pending && i_dmi_error) begin
                            stat = DMISTAT_FAILED;
                        end
                        sticky_nxt = stat;
                        pending_nxt = 1'b0;
                        dr_nxt = {last_addr, i_dmi_resp_data, stat};
                        len_nxt = 6'(DRLEN);
                    end
                    default: begin
                        len_nxt = 6'd1;               // bypass and unknown codes
                    end
                endcase
            end
            TAP_SHIFT_DR: begin
                dr_nxt = {1'b0, dr[DRLEN-1:1]};
                dr_nxt[dr_len - 6'd1] = i_tdi;        // tdi enters at the chain's top
            end
            TAP_UPDATE_DR: begin
                if (upd_ctrl && dr[DTMCONTROL_DMIRESET]) begin
                    sticky_nxt = DMISTAT_SUCCESS;
                end
                if (upd_dbus) begin
                    addr_nxt = dr[DRLEN-1:34];
                    if (dbus_op != 2'd0 && sticky == DMISTAT_SUCCESS && busy_q) begin
                        sticky_nxt = DMISTAT_BUSY;    // request dropped
                    end
                end
                if (req_fire) begin
                    pending_nxt = 1'b1;
                end
            end
            TAP_CAPTURE_IR: begin
                dr_nxt = '0;
                dr_nxt[IRLEN-1:0] = ir_t'(1);         // fixed 01 pattern
            end
            TAP_SHIFT_IR: begin
                dr_nxt = '0;
                dr_nxt[IRLEN-1:0] = {i_tdi, dr[IRLEN-1:1]};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            state <= TAP_RESET;
            dr <= '0;
            dr_len <= 6'd32;
            sticky <= DMISTAT_SUCCESS;
            pending <= 1'b0;
            busy_q <= 1'b0;
            last_addr <= '0;
        end else begin
            state <= state_nxt;
            dr <= dr_nxt;
            dr_len <= len_nxt;
            sticky <= sticky_nxt;
            pending <= pending_nxt;
            busy_q <= i_dmi_busy;             // sampled busy seen at update
            last_addr <= addr_nxt;
        end
    end

    // ir moves on the falling edge
    always_ff @(negedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            ir <= IR_IDCODE;
        end else if (state == TAP_RESET) begin
            ir <= IR_IDCODE;
        end else if (state == TAP_UPDATE_IR) begin
            ir <= dr[IRLEN-1:0];
        end
    end

    assign o_tdo = dr[0];
    assign o_dmi_req_valid = req_fire;
    assign o_dmi_req_write = (dbus_op == 2'd2);   // op 1 read, op 2 write
    assign o_dmi_req_addr = dr[DRLEN-1:34];
    assign o_dmi_req_data = dr[33:2];
    assign o_dmi_hardreset = upd_ctrl && dr[DTMCONTROL_DMIHARDRESET];

endmodule

// ==== rtl/dbg_pkg.sv ====
// debug transport package with DMI constants, instruction codes and shared types
package dbg_pkg;

    localparam int ABITS = 7;   // dmi address width
    localparam int IRLEN = 5;

    localparam int NUM_BANKS = 4;

    typedef logic [ABITS-1:0] dmi_addr_t;
    typedef logic [31:0] dmi_data_t;
    typedef logic [IRLEN-1:0] ir_t;
    typedef logic [1:0] dmi_stat_t;
    typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;
    typedef logic [7:0] wr_count_t;

    localparam dmi_data_t IDCODE = 32'h1d7a0c4b;   // bit 0 must stay set

    localparam ir_t IR_IDCODE = 5'h01;
    localparam ir_t IR_DTMCONTROL = 5'h10;
    localparam ir_t IR_DBUS = 5'h11;
    localparam ir_t IR_BYPASS = 5'h1f;

    localparam dmi_stat_t DMISTAT_SUCCESS = 2'h0;
    localparam dmi_stat_t DMISTAT_FAILED = 2'h2;
    localparam dmi_stat_t DMISTAT_BUSY = 2'h3;

    // dtmcontrol write bits
    localparam int DTMCONTROL_DMIRESET = 16;
    localparam int DTMCONTROL_DMIHARDRESET = 17;

    localparam int DRLEN = ABITS + 34;   // dbus is the longest chain

    // bank k: data at BANK_BASE+2k, counter at BANK_BASE+2k+1
    localparam dmi_addr_t BANK_BASE = 7'h04;

    typedef enum logic [3:0] {
        TAP_RESET, TAP_IDLE,
        TAP_SELECT_DR, TAP_CAPTURE_DR, TAP_SHIFT_DR,
        TAP_EXIT1_DR, TAP_PAUSE_DR, TAP_EXIT2_DR, TAP_UPDATE_DR,
        TAP_SELECT_IR, TAP_CAPTURE_IR, TAP_SHIFT_IR,
        TAP_EXIT1_IR, TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPDATE_IR
    } tap_state_t;

endpackage
